// ==== hdl/fabricPkg.sv ====
package fabricPkg;

    // pin word and user side
    localparam int pinWidth = 12;
    localparam int userWidth = 4;
    localparam int addressWidth = 6;

    // fabric counts
    localparam int blockCount = 16;
    localparam int columnHeight = 4;   // blocks per column
    localparam int switchCount = 24;
    localparam int muxCount = 8;
    localparam int candidateCount = 12;
    localparam int lutSize = 4;

    // address map
    localparam int firstSwitchAddress = 16;
    localparam int firstMuxAddress = 40;
    localparam int siteCount = 48;
    localparam int idleAddress = 63;   // 48..63 write nothing

    typedef struct packed {
        logic registered;               // use the output register
        logic [lutSize-1:0] lutTable;
    } clbSetting;

    typedef struct packed {
        logic spare;
        logic [3:0] select;             // input mux only looks at [1:0]
    } routeSetting;

    // one data field, read per site type
    typedef union packed {
        clbSetting clb;
        routeSetting route;
    } configData;

    typedef struct packed {
        logic strobe;
        logic [addressWidth-1:0] address;
        configData data;
    } configWrite;

    typedef logic [siteCount-1:0] siteStrobes;  // one-hot write enables

endpackage

// ==== hdl/padDecoder.sv ====
module padDecoder (
    input logic [fabricPkg::pinWidth-1:0] pins,
    output logic [fabricPkg::userWidth-1:0] userInputs,
    output fabricPkg::configWrite write
);

    localparam int addressWidth = fabricPkg::addressWidth;

    // bit 0 picks the mode
    always_comb begin
        if (pins[0]) begin
            userInputs = '0;    // user side reads zero while configuring
            write.strobe = 1'b1;
            write.address = pins[fabricPkg::pinWidth-1 -: addressWidth];
            write.data = pins[5:1];
        end else begin
            userInputs = pins[fabricPkg::userWidth:1];
            write.strobe = 1'b0;
            write.address = addressWidth'(fabricPkg::idleAddress);
            write.data = '0;
        end
    end

endmodule

// ==== hdl/configDecoder.sv ====
module configDecoder (
    input fabricPkg::configWrite write,
    output fabricPkg::siteStrobes strobes
);

    logic inRange;

    // addresses above the last site are ignored
    assign inRange = write.address < fabricPkg::siteCount;

    always_comb begin
        strobes = '0;
        if (write.strobe && inRange) begin
            strobes[write.address] = 1'b1;
        end
    end

endmodule

// ==== hdl/inputMux.sv ====
module inputMux (
    input logic clock,
    input logic reset,
    input logic load,
    input fabricPkg::configData setting,
    input logic [fabricPkg::userWidth-1:0] userInputs,
    output logic out
);

    logic [1:0] select;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            select <= '0;
        end else if (load) begin
            select <= setting.route.select[1:0];    // upper select bits unused here
        end
    end

    assign out = userInputs[select];

endmodule

// ==== hdl/logicBlock.sv ====
module logicBlock (
    input logic clock,
    input logic reset,
    input logic load,
    input fabricPkg::configData setting,
    input logic [1:0] sel,
    output logic out
);

    fabricPkg::clbSetting stored;
    logic direct;
    logic held;

    // table and registered flag load together
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            stored <= '0;
        end else if (load) begin
            stored <= setting.clb;
        end
    end

    assign direct = stored.lutTable[sel];

    // captures every cycle, whether or not it is selected
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            held <= 1'b0;
        end else begin
            held <= direct;
        end
    end

    assign out = stored.registered ? held : direct;

endmodule

// ==== hdl/switchBox.sv ====
module switchBox (
    input logic clock,
    input logic reset,
    input logic load,
    input fabricPkg::configData setting,
    input logic [fabricPkg::candidateCount-1:0] candidates,
    output logic out
);

    logic [3:0] select;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            select <= '0;
        end else if (load) begin
            select <= setting.route.select;
        end
    end

    // selects past the last candidate read zero
    assign out = (select < fabricPkg::candidateCount) ? candidates[select] : 1'b0;

endmodule

// ==== hdl/routingFabric.sv ====
module routingFabric (
    input logic clock,
    input logic reset,
    input fabricPkg::siteStrobes strobes,
    input fabricPkg::configData setting,
    input logic [fabricPkg::userWidth-1:0] userInputs,
    output logic [fabricPkg::columnHeight-1:0] outputs
);

    localparam int blockCount = fabricPkg::blockCount;
    localparam int columnHeight = fabricPkg::columnHeight;
    localparam int candidateCount = fabricPkg::candidateCount;
    localparam int columnCount = blockCount / columnHeight;
    localparam int switchesPerColumn = 2 * columnHeight;   // two select bits per block
    localparam int padCount = candidateCount - switchesPerColumn;

    logic [blockCount-1:0] blockOut;
    logic [fabricPkg::muxCount-1:0] muxOut;
    logic [fabricPkg::switchCount-1:0] switchOut;
    logic [candidateCount-1:0] columnCandidates [1:columnCount-1];

    // candidates seen by the switch boxes of each routed column
    assign columnCandidates[1] = blockOut[candidateCount-1:0];
    assign columnCandidates[2] = blockOut[blockCount-1 -: candidateCount];
    assign columnCandidates[3] = {{padCount{1'b0}},
                                  blockOut[blockCount-1 -: switchesPerColumn]};  // zero padded

    for (genvar m = 0; m < fabricPkg::muxCount; m++) begin : gMux
        inputMux mux (
            .clock,
            .reset,
            .load(strobes[fabricPkg::firstMuxAddress + m]),
            .setting,
            .userInputs,
            .out(muxOut[m])
        );
    end

    for (genvar k = 0; k < fabricPkg::switchCount; k++) begin : gSwitch
        switchBox box (
            .clock,
            .reset,
            .load(strobes[fabricPkg::firstSwitchAddress + k]),
            .setting,
            .candidates(columnCandidates[1 + k / switchesPerColumn]),
            .out(switchOut[k])
        );
    end

    for (genvar b = 0; b < blockCount; b++) begin : gBlock
        logic [1:0] sel;

        if (b < columnHeight) begin : gFirst
            assign sel = muxOut[2*b +: 2];    // column zero from the input muxes
        end else begin : gRouted
            assign sel = switchOut[2*(b-columnHeight) +: 2];
        end

        logicBlock clb (
            .clock,
            .reset,
            .load(strobes[b]),
            .setting,
            .sel,
            .out(blockOut[b])
        );
    end

    // last column drives the pins
    assign outputs = blockOut[blockCount-1 -: columnHeight];

    // every path back to the pins is settled once reset is released
    assert property (@(posedge clock) disable iff (reset) !$isunknown(outputs))
    else $error("routingFabric: unknown value on fabric outputs");

endmodule

// ==== hdl/fpgaChip.sv ====
module fpgaChip (
    input logic clock,
    input logic reset,
    input logic [fabricPkg::pinWidth-1:0] pins,
    output logic [fabricPkg::pinWidth-1:0] pinsOut
);

    localparam int outWidth = fabricPkg::columnHeight;

    logic [fabricPkg::userWidth-1:0] userInputs;
    fabricPkg::configWrite write;
    fabricPkg::siteStrobes strobes;
    logic [outWidth-1:0] fabricOut;

    padDecoder pads (
        .pins,
        .userInputs,
        .write
    );

    configDecoder decoder (
        .write,
        .strobes
    );

    routingFabric fabric (
        .clock,
        .reset,
        .strobes,
        .setting(write.data),
        .userInputs,
        .outputs(fabricOut)
    );

    // upper pins unused
    assign pinsOut = {{(fabricPkg::pinWidth - outWidth){1'b0}}, fabricOut};

endmodule

// ==== sim/tbFpgaChip.sv ====
module tbFpgaChip;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [2:0] testId;
        logic [11:0] pinWord;
        logic [1:0] edges;      // rising edges before the check
        logic check;
        logic [11:0] expected;
    } stepRow;

    localparam int roundCount = 20;
    localparam int vectorsPerRound = 4;

    logic clock;
    logic reset;
    logic [11:0] pins;
    logic [11:0] pinsOut;

    logic [4:0] shadow [0:47];  // copy of every site setting
    logic [15:0] heldModel;
    stepRow steps[$];
    integer seed = 32'hd566109e;
    int checkCount = 0;
    int errorCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    fpgaChip i_dut (
        .clock,
        .reset,
        .pins,
        .pinsOut
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [11:0] cfgWord(input int address, input logic [4:0] data);
        return {address[5:0], data, 1'b1};
    endfunction

    function automatic logic [11:0] userWord(input logic [3:0] user);
        return {7'b0, user, 1'b0};
    endfunction

    // switch box feeding select bit bitNo of block b
    function automatic logic routed(input int b, input int bitNo, input logic [15:0] outs);
        logic [3:0] sel;
        int base;
        sel = shadow[16 + 2 * (b - 4) + bitNo][3:0];
        base = (b / 4) * 4 - 4;     // column one sees block 0 first, two block 4, three block 8
        if (sel >= 12) begin
            return 1'b0;
        end
        if (b / 4 == 3 && sel >= 8) begin
            return 1'b0;    // padded positions
        end
        return outs[base + sel];
    endfunction

    function automatic void evalBlocks(input logic [3:0] user, output logic [15:0] direct,
                                       output logic [15:0] outs);
        logic s0;
        logic s1;
        logic [3:0] lut;
        direct = '0;
        outs = '0;
        for (int b = 0; b < 16; b++) begin
            if (b < 4) begin
                s0 = user[shadow[40 + 2 * b][1:0]];
                s1 = user[shadow[41 + 2 * b][1:0]];
            end else begin
                s0 = routed(b, 0, outs);
                s1 = routed(b, 1, outs);
            end
            lut = shadow[b][3:0];
            direct[b] = lut[{s1, s0}];
            outs[b] = shadow[b][4] ? heldModel[b] : direct[b];
        end
    endfunction

    // model state follows the pins at every rising edge
    always @(posedge clock, posedge reset) begin : modelUpdate
        logic [15:0] direct;
        logic [15:0] outs;
        logic [3:0] user;
        if (reset) begin
            heldModel <= '0;
            for (int s = 0; s < 48; s++) begin
                shadow[s] <= '0;
            end
        end else begin
            user = pins[0] ? 4'b0 : pins[4:1];
            evalBlocks(user, direct, outs);
            heldModel <= direct;
            if (pins[0] && pins[11:6] < 48) begin
                shadow[pins[11:6]] <= pins[5:1];
            end
        end
    end

    task automatic addStep(input int testId, input logic [11:0] pinWord, input int edges,
                           input logic check, input logic [11:0] expected);
        stepRow row;
        row.testId = testId[2:0];
        row.pinWord = pinWord;
        row.edges = edges[1:0];
        row.check = check;
        row.expected = expected;
        steps.push_back(row);
    endtask

    task automatic writeRow(input int testId, input int address, input logic [4:0] data);
        addStep(testId, cfgWord(address, data), 1, 1'b0, '0);
    endtask

    task automatic userRow(input int testId, input logic [3:0] user, input int edges,
                           input logic [11:0] expected);
        addStep(testId, userWord(user), edges, 1'b1, expected);
    endtask

    task automatic buildTable();
        userRow(1, 4'h0, 0, 12'h000);
        userRow(1, 4'h5, 0, 12'h000);
        userRow(1, 4'hf, 0, 12'h000);
        userRow(1, 4'ha, 1, 12'h000);
        // xor of user 0,1 to pin 0 and of user 2,3 to pin 1
        writeRow(2, 40, 5'h00);
        writeRow(2, 41, 5'h01);
        writeRow(2, 42, 5'h02);
        writeRow(2, 43, 5'h03);
        writeRow(2, 0, 5'h06);
        writeRow(2, 1, 5'h06);
        writeRow(2, 20, 5'h00);     // block 6 from block 0
        writeRow(2, 28, 5'h02);     // block 10 from block 6
        writeRow(2, 32, 5'h02);     // block 12 from block 10
        writeRow(2, 18, 5'h01);
        writeRow(2, 26, 5'h01);
        writeRow(2, 34, 5'h01);
        writeRow(2, 6, 5'h0a);
        writeRow(2, 10, 5'h0a);
        writeRow(2, 12, 5'h0a);
        writeRow(2, 5, 5'h0a);
        writeRow(2, 9, 5'h0a);
        writeRow(2, 13, 5'h0a);
        userRow(2, 4'h0, 0, 12'h000);
        userRow(2, 4'h1, 0, 12'h001);
        userRow(2, 4'h6, 0, 12'h003);
        userRow(2, 4'h8, 0, 12'h002);
        userRow(2, 4'hf, 0, 12'h000);
        userRow(2, 4'h5, 0, 12'h003);
        writeRow(3, 12, 5'h1a);     // block 12 registered
        userRow(3, 4'h5, 0, 12'h002);
        userRow(3, 4'h5, 0, 12'h003);
        userRow(3, 4'h0, 0, 12'h001);
        userRow(3, 4'h0, 0, 12'h000);
        userRow(3, 4'h1, 1, 12'h001);
        writeRow(4, 12, 5'h0a);
        writeRow(4, 14, 5'h0a);
        writeRow(4, 36, 5'h02);     // block 14 from block 10
        userRow(4, 4'h1, 0, 12'h005);
        userRow(4, 4'h3, 0, 12'h000);
        userRow(4, 4'h2, 0, 12'h005);
        writeRow(4, 36, 5'h08);
        userRow(4, 4'h1, 0, 12'h001);
        writeRow(4, 36, 5'h0b);
        userRow(4, 4'h1, 0, 12'h001);
        writeRow(4, 36, 5'h0c);
        userRow(4, 4'h2, 0, 12'h001);
        writeRow(4, 36, 5'h0f);
        userRow(4, 4'h1, 0, 12'h001);
        // data bits would look like user inputs 0 and 2
        addStep(5, cfgWord(48, 5'h05), 1, 1'b1, 12'h000);
        addStep(5, cfgWord(55, 5'h15), 1, 1'b1, 12'h000);
        addStep(5, cfgWord(63, 5'h05), 1, 1'b1, 12'h000);
        userRow(5, 4'h1, 0, 12'h001);
        userRow(5, 4'h4, 0, 12'h002);
        userRow(5, 4'h5, 0, 12'h003);
    endtask

    function automatic string testName(input int id);
        case (id)
            1: return "reset state";
            2: return "combinational chain";
            3: return "registered block";
            4: return "zero candidates";
            5: return "ignored writes";
            default: return "random configurations";
        endcase
    endfunction

    task automatic checkPins(input int testId, input logic [11:0] expected, inout int fails);
        checkCount++;
        if (pinsOut !== expected) begin
            $display("ERR %0t: test %0d pins read %h, expected %h", $time, testId, pinsOut,
                     expected);
            errorCount++;
            fails++;
        end
    endtask

    task automatic applyStep(input stepRow row, inout int fails);
        @(negedge clock);
        pins = row.pinWord;
        repeat (row.edges) @(posedge clock);
        #1;
        if (row.check) begin
            checkPins(row.testId, row.expected, fails);
        end
    endtask

    task automatic randomRound(inout int fails);
        logic [31:0] r;
        logic [4:0] data;
        logic [3:0] user;
        logic [15:0] direct;
        logic [15:0] outs;
        for (int site = 0; site < 48; site++) begin
            r = $random(seed);
            if (site < 16) begin
                data = {1'b0, r[3:0]};
            end else if (site >= 32 && site < 40 && r[4]) begin
                data = {r[6], 1'b1, r[3], r[1:0]};     // column three, past the real candidates
            end else if (site < 40) begin
                data = {r[6], 2'b00, r[1:0]};   // previous column only, so no loops
            end else begin
                data = r[4:0];
            end
            @(negedge clock);
            pins = cfgWord(site, data);
        end
        for (int v = 0; v < vectorsPerRound; v++) begin
            r = $random(seed);
            user = r[3:0];
            @(negedge clock);
            pins = userWord(user);
            #1;
            evalBlocks(user, direct, outs);
            checkPins(6, {8'b0, outs[15:12]}, fails);
        end
    endtask

    initial begin : run
        int fails;
        int total;
        pins = '0;
        reset = 1'b1;
        buildTable();
        total = 8 + roundCount * (48 + vectorsPerRound);
        foreach (steps[i]) begin
            total += int'(steps[i].edges) + 1;
        end
        cycleLimit = 2 * total;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        fails = 0;
        foreach (steps[i]) begin
            applyStep(steps[i], fails);
            if (i == steps.size() - 1 || steps[i + 1].testId != steps[i].testId) begin
                $display("test %0d (%s) done, %0d errors", steps[i].testId,
                         testName(steps[i].testId), fails);
                fails = 0;
            end
        end
        for (int round = 0; round < roundCount; round++) begin
            randomRound(fails);
        end
        $display("test 6 (%s) done, %0d errors", testName(6), fails);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/fabricPkg.sv
hdl/padDecoder.sv
hdl/configDecoder.sv
hdl/inputMux.sv
hdl/logicBlock.sv
hdl/switchBox.sv
hdl/routingFabric.sv
hdl/fpgaChip.sv
sim/tbFpgaChip.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module tbFpgaChip -f files.f \
    && ./obj_dir/VtbFpgaChip > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "^Everything OK$" sim.log && exit 0 || exit 1
